//--- verilog/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Shape of one cache line as it leaves the buffer.
    localparam int LINE_BEATS = 8;
    localparam int WORD_W = 32;
    localparam int LINE_W = LINE_BEATS * WORD_W;

    // Lines are 32-byte aligned, so the low five address bits are always zero.
    localparam int LINE_ADDR_W = 27;

    localparam int BEAT_W = $clog2(LINE_BEATS);

    typedef enum logic [3:0] {
        IDLE   = 4'd0,  // Waiting for a valid head slot.
        PULL   = 4'd1,  // Address phase.
        SEND_0 = 4'd2,
        SEND_1 = 4'd3,
        SEND_2 = 4'd4,
        SEND_3 = 4'd5,
        SEND_4 = 4'd6,
        SEND_5 = 4'd7,
        SEND_6 = 4'd8,
        SEND_7 = 4'd9,  // Last beat.
        DONE   = 4'd10  // Waiting for the write response.
    } wr_state_t;

endpackage

`default_nettype wire

//--- verilog/wb_fill.sv
`default_nettype none

module wb_fill #(
    parameter int SLOTS = 4
) (
    input  wire              clk,
    input  wire              rstn,

    input  wire              line_strobe,
    input  wire [SLOTS-1:0]  slot_valid,

    output logic [SLOTS-1:0] load_sel,
    output logic             full
);

    localparam int PTR_W = $clog2(SLOTS);

    logic [PTR_W-1:0] wr_ptr;

    // The ring fills in order, so the slot at the write pointer is the
    // next one the engine will free once everything ahead of it has drained.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (line_strobe) begin
            wr_ptr <= wr_ptr + 1'b1;  // Wraps since SLOTS is a power of two.
        end
    end

    always_comb begin
        load_sel = '0;
        if (line_strobe) begin
            load_sel = SLOTS'(1) << wr_ptr;
        end
    end

    assign full = slot_valid[wr_ptr];

    // A strobe into an occupied slot would overwrite a line that has not
    // yet gone out to memory.
    assert property (@(posedge clk) disable iff (!rstn)
        line_strobe |-> !full)
        else $error("line strobe while the buffer is full");

endmodule

`default_nettype wire

//--- verilog/wb_slot.sv
`default_nettype none

module wb_slot
    import wb_pkg::*;
(
    input  wire                    clk,
    input  wire                    rstn,

    input  wire                    load,
    input  wire                    free,
    input  wire [LINE_ADDR_W-1:0]  line_addr,
    input  wire [LINE_W-1:0]       line_data,
    input  wire [BEAT_W-1:0]       beat,

    output logic                   valid,
    output logic [LINE_ADDR_W-1:0] addr,
    output logic [WORD_W-1:0]      word
);

    logic [LINE_BEATS-1:0][WORD_W-1:0] words;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (free) begin
            valid <= 1'b0;
        end
    end

    // Word 0 sits in the lowest bits of the line.
    always_ff @(posedge clk) begin
        if (load) begin
            addr  <= line_addr;
            words <= line_data;
        end
    end

    assign word = words[beat];

    // The fill unit must not reuse a slot in the same cycle the engine releases it.
    assert property (@(posedge clk) disable iff (!rstn)
        valid |-> !(load && free))
        else $error("slot loaded and freed in the same cycle");

endmodule

`default_nettype wire

//--- verilog/wb_axi_write.sv
`default_nettype none

module wb_axi_write
    import wb_pkg::*;
#(
    parameter int SLOTS = 4
) (
    input  wire                          clk,
    input  wire                          rstn,

    input  wire                          lock,

    input  wire [SLOTS-1:0]              slot_valid,
    input  wire [SLOTS*LINE_ADDR_W-1:0]  slot_addr,
    input  wire [SLOTS*WORD_W-1:0]       slot_word,
    output logic [BEAT_W-1:0]            beat,
    output logic [SLOTS-1:0]             free_sel,

    output logic                         awvalid,
    output logic [31:0]                  awaddr,
    input  wire                          awready,

    output logic                         wvalid,
    output logic [WORD_W-1:0]            wdata,
    output logic                         wlast,
    input  wire                          wready,

    input  wire                          bvalid,
    output logic                         bready
);

    localparam int PTR_W = $clog2(SLOTS);
    localparam int OFFS_W = 32 - LINE_ADDR_W;

    wr_state_t        state;
    wr_state_t        state_nxt;
    logic [PTR_W-1:0] rd_ptr;
    logic             head_valid;
    logic             resp_done;
    logic [3:0]       send_idx;

    assign head_valid = slot_valid[rd_ptr];
    assign resp_done = bready && bvalid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= IDLE;
            rd_ptr <= '0;
        end else begin
            state <= state_nxt;
            if (resp_done) begin
                rd_ptr <= rd_ptr + 1'b1;  // Head moves on with the response.
            end
        end
    end

    always_comb begin
        case (state)
            IDLE: begin
                if (!lock && head_valid) state_nxt = PULL;
                else                     state_nxt = IDLE;
            end
            PULL: begin
                if (awready) state_nxt = SEND_0;
                else         state_nxt = PULL;
            end
            SEND_0: begin
                if (wready) state_nxt = SEND_1;
                else        state_nxt = SEND_0;
            end
            SEND_1: begin
                if (wready) state_nxt = SEND_2;
                else        state_nxt = SEND_1;
            end
            SEND_2: begin
                if (wready) state_nxt = SEND_3;
                else        state_nxt = SEND_2;
            end
            SEND_3: begin
                if (wready) state_nxt = SEND_4;
                else        state_nxt = SEND_3;
            end
            SEND_4: begin
                if (wready) state_nxt = SEND_5;
                else        state_nxt = SEND_4;
            end
            SEND_5: begin
                if (wready) state_nxt = SEND_6;
                else        state_nxt = SEND_5;
            end
            SEND_6: begin
                if (wready) state_nxt = SEND_7;
                else        state_nxt = SEND_6;
            end
            SEND_7: begin
                if (wready) state_nxt = DONE;
                else        state_nxt = SEND_7;
            end
            DONE: begin
                if (bvalid) state_nxt = IDLE;
                else        state_nxt = DONE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    // All channel outputs follow the state alone, so a stall holds them steady.
    assign awvalid = (state == PULL);
    assign wvalid = (state >= SEND_0) && (state <= SEND_7);
    assign wlast = (state == SEND_7);
    assign bready = (state == DONE);

    // The send states are consecutive, so the beat index is the offset from SEND_0.
    assign send_idx = 4'(state) - 4'(SEND_0);
    assign beat = wvalid ? send_idx[BEAT_W-1:0] : '0;

    assign awaddr = {slot_addr[rd_ptr*LINE_ADDR_W +: LINE_ADDR_W], {OFFS_W{1'b0}}};
    assign wdata = slot_word[rd_ptr*WORD_W +: WORD_W];

    always_comb begin
        free_sel = '0;
        if (resp_done) begin
            free_sel = SLOTS'(1) << rd_ptr;
        end
    end

    // The head slot's contents must not shift under a stalled transfer.
    assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr changed before the address transfer");

    assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("wvalid dropped or wdata changed before the beat transfer");

endmodule

`default_nettype wire

//--- verilog/wb_top.sv
`default_nettype none

module wb_top
    import wb_pkg::*;
#(
    parameter int SLOTS = 4
) (
    input  wire                   clk,
    input  wire                   rstn,

    input  wire                   line_strobe,
    input  wire [LINE_ADDR_W-1:0] line_addr,
    input  wire [LINE_W-1:0]      line_data,
    output logic                  full,

    input  wire                   lock,

    output logic                  awvalid,
    output logic [31:0]           awaddr,
    input  wire                   awready,
    output logic                  wvalid,
    output logic [WORD_W-1:0]     wdata,
    output logic                  wlast,
    input  wire                   wready,
    input  wire                   bvalid,
    output logic                  bready
);

    wire [SLOTS-1:0]             load_sel;
    wire [SLOTS-1:0]             free_sel;
    wire [SLOTS-1:0]             slot_valid;
    wire [SLOTS*LINE_ADDR_W-1:0] slot_addr;
    wire [SLOTS*WORD_W-1:0]      slot_word;
    wire [BEAT_W-1:0]            beat;

    wb_fill #(
        .SLOTS (SLOTS)
    ) u_fill (
        .clk         (clk),
        .rstn        (rstn),
        .line_strobe (line_strobe),
        .slot_valid  (slot_valid),
        .load_sel    (load_sel),
        .full        (full)
    );

    for (genvar i = 0; i < SLOTS; i++) begin : g_slot
        wb_slot u_slot (
            .clk       (clk),
            .rstn      (rstn),
            .load      (load_sel[i]),
            .free      (free_sel[i]),
            .line_addr (line_addr),
            .line_data (line_data),
            .beat      (beat),
            .valid     (slot_valid[i]),
            .addr      (slot_addr[i*LINE_ADDR_W +: LINE_ADDR_W]),
            .word      (slot_word[i*WORD_W +: WORD_W])
        );
    end

    wb_axi_write #(
        .SLOTS (SLOTS)
    ) u_axi_write (
        .clk        (clk),
        .rstn       (rstn),
        .lock       (lock),
        .slot_valid (slot_valid),
        .slot_addr  (slot_addr),
        .slot_word  (slot_word),
        .beat       (beat),
        .free_sel   (free_sel),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wlast      (wlast),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready)
    );

endmodule

`default_nettype wire

//--- tests/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset lets go just after an edge, like every other input.
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rstn = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_top.sv
`default_nettype none

module tb_top
    import wb_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SLOTS = 4;
    localparam logic [31:0] SEED = 32'd56578;
    localparam int NUM_TESTS = 5;
    localparam int LINES_PER_TEST = 8;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * LINES_PER_TEST * 200;

    logic                   clk;
    logic                   rstn;
    logic                   line_strobe;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [LINE_W-1:0]      line_data;
    logic                   full;
    logic                   lock;
    logic                   awvalid;
    logic [31:0]            awaddr;
    logic                   awready;
    logic                   wvalid;
    logic [WORD_W-1:0]      wdata;
    logic                   wlast;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;

    // Lines still owed to memory, oldest first.
    logic [LINE_ADDR_W-1:0] addr_q[$];
    logic [LINE_W-1:0]      data_q[$];

    logic [31:0] stim_rng;
    logic        backpressure;
    logic        expect_quiet;  // Set while lock holds an idle engine.
    int          errors;
    int          bursts_done;
    int          passed;
    int          failed;
    int          start_errors;

    tb_clkgen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (4)
    ) u_clkgen (
        .clk  (clk),
        .rstn (rstn)
    );

    wb_top #(
        .SLOTS (SLOTS)
    ) dut (
        .clk         (clk),
        .rstn        (rstn),
        .line_strobe (line_strobe),
        .line_addr   (line_addr),
        .line_data   (line_data),
        .full        (full),
        .lock        (lock),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .awready     (awready),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wlast       (wlast),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_addr(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // Strobes one random line once the next slot is free.
    task automatic push_random_line();
        logic [LINE_ADDR_W-1:0] a;
        logic [LINE_W-1:0]      d;
        stim_rng = xorshift(stim_rng);
        a = stim_rng[LINE_ADDR_W-1:0];
        for (int i = 0; i < LINE_BEATS; i++) begin
            stim_rng = xorshift(stim_rng);
            d[i*WORD_W +: WORD_W] = stim_rng;
        end
        while (full) begin
            @(posedge clk);
            #2;
        end
        line_strobe = 1'b1;
        line_addr = a;
        line_data = d;
        addr_q.push_back(a);
        data_q.push_back(d);
        @(posedge clk);
        #2;
        line_strobe = 1'b0;
    endtask

    task automatic wait_drain();
        while (addr_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic start_test();
        start_errors = errors;
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == start_errors) begin
            $display("test %0d %s: ok", num, name);
            passed++;
        end else begin
            $display("test %0d %s: FAILED with %0d errors", num, name, errors - start_errors);
            failed++;
        end
    endtask

    // Memory side. Handshakes are sampled at the edge and answered 2 ns later.
    initial begin : responder
        logic [31:0] resp_rng;
        logic        got_last;
        logic        got_resp;
        logic        resp_pending;
        logic [1:0]  resp_wait;
        resp_rng = ~SEED;
        resp_pending = 1'b0;
        resp_wait = 2'd0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        forever begin
            @(posedge clk);
            got_last = wvalid && wready && wlast;
            got_resp = bvalid && bready;
            #2;
            resp_rng = xorshift(resp_rng);
            awready = !backpressure || (resp_rng[1:0] != 2'b00);
            wready = !backpressure || (resp_rng[3:2] != 2'b00);
            if (got_resp) bvalid = 1'b0;
            if (got_last) begin
                resp_pending = 1'b1;
                resp_wait = resp_rng[5:4];  // Up to three idle cycles before the response.
            end
            if (resp_pending) begin
                if (resp_wait == 2'd0) begin
                    bvalid = 1'b1;
                    resp_pending = 1'b0;
                end else begin
                    resp_wait = resp_wait - 2'd1;
                end
            end
        end
    end

    // Checks every AXI transfer against the head of the model queue.
    initial begin : monitor
        logic        in_burst;
        int          beat_idx;
        logic        aw_stalled;
        logic        w_stalled;
        logic [31:0] held_awaddr;
        logic [WORD_W-1:0] held_wdata;
        logic        held_wlast;
        in_burst = 1'b0;
        beat_idx = 0;
        aw_stalled = 1'b0;
        w_stalled = 1'b0;
        held_awaddr = '0;
        held_wdata = '0;
        held_wlast = 1'b0;
        forever begin
            @(posedge clk);
            if (rstn) begin
                if (expect_quiet) check_flag("awvalid", awvalid, 1'b0);
                if (aw_stalled) begin
                    check_flag("awvalid", awvalid, 1'b1);
                    check_addr("awaddr", awaddr, held_awaddr);
                end
                if (w_stalled) begin
                    check_flag("wvalid", wvalid, 1'b1);
                    check_word("wdata", wdata, held_wdata);
                    check_flag("wlast", wlast, held_wlast);
                end
                if (awvalid && awready) begin
                    if (addr_q.size() == 0) begin
                        report_error("address transfer with no line waiting");
                    end else begin
                        check_addr("awaddr", awaddr, {addr_q[0], 5'b0});
                    end
                    in_burst = 1'b1;
                    beat_idx = 0;
                end
                if (wvalid && wready) begin
                    if (!in_burst || beat_idx >= LINE_BEATS || data_q.size() == 0) begin
                        report_error("data beat outside of a burst");
                    end else begin
                        check_word("wdata", wdata, data_q[0][beat_idx*WORD_W +: WORD_W]);
                        check_flag("wlast", wlast, beat_idx == LINE_BEATS - 1);
                    end
                    beat_idx++;
                end
                if (bvalid && bready) begin
                    if (beat_idx != LINE_BEATS) report_error("response before all eight beats");
                    if (addr_q.size() != 0) begin
                        void'(addr_q.pop_front());
                        void'(data_q.pop_front());
                    end
                    in_burst = 1'b0;
                    bursts_done++;
                end
                aw_stalled = awvalid && !awready;
                held_awaddr = awaddr;
                w_stalled = wvalid && !wready;
                held_wdata = wdata;
                held_wlast = wlast;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d lines undelivered",
                 TIMEOUT_CYCLES, addr_q.size());
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        int done_mark;
        line_strobe = 1'b0;
        line_addr = '0;
        line_data = '0;
        lock = 1'b0;
        backpressure = 1'b0;
        expect_quiet = 1'b0;
        stim_rng = SEED;
        errors = 0;
        bursts_done = 0;
        passed = 0;
        failed = 0;
        start_errors = 0;
        @(posedge rstn);
        @(posedge clk);
        #2;

        start_test();
        check_flag("awvalid", awvalid, 1'b0);
        check_flag("wvalid", wvalid, 1'b0);
        check_flag("bready", bready, 1'b0);
        check_flag("full", full, 1'b0);
        push_random_line();
        wait_drain();
        finish_test(1, "single line");

        start_test();
        for (int i = 0; i < LINES_PER_TEST; i++) push_random_line();
        wait_drain();
        finish_test(2, "ordering");

        start_test();
        backpressure = 1'b1;
        for (int i = 0; i < LINES_PER_TEST; i++) push_random_line();
        wait_drain();
        backpressure = 1'b0;
        finish_test(3, "back-pressure");

        // The engine is idle here, so lock must keep the address channel quiet.
        start_test();
        lock = 1'b1;
        expect_quiet = 1'b1;
        for (int i = 0; i < 3; i++) push_random_line();
        repeat (20) @(posedge clk);
        #2;
        if (addr_q.size() != 3) report_error("lines left the buffer while lock was high");
        lock = 1'b0;
        expect_quiet = 1'b0;
        wait_drain();
        finish_test(4, "lock");

        start_test();
        lock = 1'b1;
        expect_quiet = 1'b1;
        for (int i = 0; i < SLOTS; i++) push_random_line();
        check_flag("full", full, 1'b1);
        lock = 1'b0;
        expect_quiet = 1'b0;
        done_mark = bursts_done;
        while (bursts_done == done_mark) begin
            @(posedge clk);
            #2;
        end
        check_flag("full", full, 1'b0);
        push_random_line();
        wait_drain();
        finish_test(5, "full");

        $display("summary: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/wb_pkg.sv
verilog/wb_fill.sv
verilog/wb_slot.sv
verilog/wb_axi_write.sv
verilog/wb_top.sv
tests/tb_clkgen.sv
tests/tb_top.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_top
FILELIST := tb.f
OBJ_DIR  := obj_dir
PASS_MSG := all tests passed

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
